// ==== logic/sg_pkg.sv ====
//========================================
// scatter-gather walker definitions
// walker states, command register map and
// descriptor field positions
//========================================
`default_nettype none

package sg_pkg;

   // walker states, also reported on err_o
   typedef enum logic [2:0] {
      ST_IDLE     = 3'd0,
      ST_CMD      = 3'd1,   // taking command writes
      ST_DESC_REQ = 3'd2,   // fetching descriptor
      ST_BUF_REQ  = 3'd3,   // buffer burst
      ST_BUF_WAIT = 3'd4,   // waiting on data side
      ST_NEXT     = 3'd5,   // follow next pointer
      ST_END      = 3'd6,
      ST_PANIC    = 3'd7    // bus error holds until reset
   } sg_state_e;

   // command register addresses
   typedef enum logic [1:0] {
      CMD_CTRL     = 2'd0,
      CMD_COUNT    = 2'd1,
      CMD_SRC_DESC = 2'd2,
      CMD_DST_DESC = 2'd3   // also the go command
   } sg_cmd_e;

   // descriptor word 0
   localparam int DESC_LAST_BIT = 20;
   localparam int DESC_LEN_LSB  = 3;    // length in 8-byte beats
   localparam int DESC_LEN_MSB  = 18;
   // addresses and pointers are beat aligned
   localparam int DESC_ADR_LSB  = 3;

   // direction enables in ss_dc_i
   localparam int EN_READ_BIT   = 1;
   localparam int EN_WRITE_BIT  = 2;

endpackage

`default_nettype wire

// ==== logic/sg_ctrl.sv ====
//========================================
// scatter-gather walker FSM
// sequences descriptor fetch, buffer
// bursts, pause, end and panic
//========================================
`timescale 1ns/1ps
`default_nettype none

module sg_ctrl (
   input  logic        wb_clk_i,
   input  logic        wb_rst_i,
   input  logic        rw_i,
   input  logic        ss_we_i,
   input  logic [1:0]  ss_adr_i,
   input  logic [23:0] ss_dc_i,
   input  logic        ss_start_i,
   input  logic        ss_stop_i,
   input  logic        ss_end_i,
   input  logic        ss_done_i,
   input  logic        wbs_ack_i,
   input  logic        wbs_err_i,
   input  logic        buf_final_i,
   input  logic        desc_second_i,
   input  logic        sg_last_i,
   input  logic        cmd_go_i,
   output logic        bus_start_o,
   output logic        addr_sel_o,
   output logic        bus_inc_o,
   output logic        bus_stop_o,
   output logic        bus_we_o,
   output logic        buf_load_o,
   output logic        buf_inc_o,
   output logic        word_take_o,
   output logic        ss_xfer_o,
   output logic        ss_last_o,
   output logic [2:0]  err_o,
   output logic        c_done_o,
   output logic [7:0]  sg_state_o
);

   sg_pkg::sg_state_e state_q, state_n;
   sg_pkg::sg_state_e err_q, err_n;
   logic moved_q, moved_n;   // a beat moved since last burst start
   logic dir_en;

   assign dir_en = rw_i ? ss_dc_i[sg_pkg::EN_WRITE_BIT] : ss_dc_i[sg_pkg::EN_READ_BIT];

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         state_q <= sg_pkg::ST_IDLE;
         err_q   <= sg_pkg::ST_IDLE;
         moved_q <= 1'b0;
      end else begin
         state_q <= state_n;
         err_q   <= err_n;
         moved_q <= moved_n;
      end
   end

   always_comb begin
      state_n     = state_q;
      err_n       = err_q;
      moved_n     = moved_q;
      bus_start_o = 1'b0;
      addr_sel_o  = 1'b0;       // 0 next pointer, 1 buffer
      bus_inc_o   = 1'b0;
      bus_stop_o  = 1'b0;
      bus_we_o    = 1'b0;
      buf_load_o  = 1'b0;
      buf_inc_o   = 1'b0;
      word_take_o = 1'b0;
      ss_xfer_o   = 1'b0;
      ss_last_o   = 1'b0;
      case (state_q)
         sg_pkg::ST_IDLE: begin
            if (ss_we_i && ss_adr_i == sg_pkg::CMD_CTRL) begin   // ctrl write opens a command
               state_n = sg_pkg::ST_CMD;
            end
         end
         sg_pkg::ST_CMD: begin
            if (cmd_go_i) begin
               err_n   = sg_pkg::ST_IDLE;
               moved_n = 1'b0;
               if (dir_en) begin
                  state_n = sg_pkg::ST_NEXT;
               end else begin
                  state_n = sg_pkg::ST_IDLE;
               end
            end
         end
         sg_pkg::ST_NEXT: begin
            if (sg_last_i) begin
               ss_xfer_o = 1'b1;   // final pulse marks the job end
               ss_last_o = 1'b1;
               state_n   = sg_pkg::ST_END;
            end else begin
               bus_start_o = 1'b1;   // fetch is always a read
               state_n     = sg_pkg::ST_DESC_REQ;
            end
         end
         sg_pkg::ST_DESC_REQ: begin
            if (wbs_err_i) begin
               err_n      = state_q;
               bus_stop_o = 1'b1;
               state_n    = sg_pkg::ST_PANIC;
            end else if (wbs_ack_i) begin
               word_take_o = 1'b1;
               bus_inc_o   = 1'b1;
               if (desc_second_i) begin
                  bus_stop_o = 1'b1;
                  state_n    = sg_pkg::ST_BUF_WAIT;
               end else begin
                  buf_load_o = 1'b1;   // length and buffer address
               end
            end
         end
         sg_pkg::ST_BUF_WAIT: begin
            if (ss_end_i && moved_q) begin
               state_n = sg_pkg::ST_END;
            end else if (ss_start_i) begin
               bus_start_o = 1'b1;
               addr_sel_o  = 1'b1;
               bus_we_o    = rw_i;
               moved_n     = 1'b0;
               state_n     = sg_pkg::ST_BUF_REQ;
            end
         end
         sg_pkg::ST_BUF_REQ: begin
            if (wbs_err_i) begin
               err_n      = state_q;
               bus_stop_o = 1'b1;
               state_n    = sg_pkg::ST_PANIC;
            end else if (wbs_ack_i) begin
               bus_inc_o = 1'b1;
               buf_inc_o = 1'b1;
               ss_xfer_o = 1'b1;
               moved_n   = 1'b1;
               if (buf_final_i) begin
                  bus_stop_o = 1'b1;
                  state_n    = sg_pkg::ST_NEXT;
               end else if (ss_stop_i) begin
                  bus_stop_o = 1'b1;   // pause keeps count and address
                  state_n    = sg_pkg::ST_BUF_WAIT;
               end
            end
         end
         sg_pkg::ST_END: begin
            if (ss_done_i) begin
               state_n = sg_pkg::ST_IDLE;
            end
         end
         default: begin
            state_n = sg_pkg::ST_PANIC;   // only reset leaves panic
         end
      endcase
   end

   assign err_o      = err_q;
   assign c_done_o   = (state_q == sg_pkg::ST_IDLE) || (state_q == sg_pkg::ST_END);
   assign sg_state_o = {sg_last_i, 4'b0000, state_q};

   // the closing last pulse follows at least one moved beat
   assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      ss_last_o |-> moved_q);

endmodule

`default_nettype wire

// ==== logic/sg_buf_cnt.sv ====
//========================================
// buffer counter
// buffer beat address and remaining
// length of the current descriptor
//========================================
`timescale 1ns/1ps
`default_nettype none

module sg_buf_cnt (
   input  logic        wb_clk_i,
   input  logic        wb_rst_i,
   input  logic [31:0] wbs_dat_i,
   input  logic [31:0] wbs_dat64_i,
   input  logic        buf_load_i,
   input  logic        buf_inc_i,
   output logic [31:sg_pkg::DESC_ADR_LSB] buf_adr_o,
   output logic [15:0] buf_len_o,
   output logic        buf_final_o
);

   logic [15:0] len_q;   // beats still to move

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         len_q <= '0;
      end else if (buf_load_i) begin
         len_q <= wbs_dat_i[sg_pkg::DESC_LEN_MSB:sg_pkg::DESC_LEN_LSB];
      end else if (buf_inc_i) begin
         len_q <= len_q - 1'b1;
      end
   end

   // buffer address sits in the upper half of descriptor word 0
   always_ff @(posedge wb_clk_i) begin
      if (buf_load_i) begin
         buf_adr_o <= wbs_dat64_i[31:sg_pkg::DESC_ADR_LSB];
      end else if (buf_inc_i) begin
         buf_adr_o <= buf_adr_o + 1'b1;   // one 8-byte beat
      end
   end

   assign buf_len_o   = len_q;
   assign buf_final_o = (len_q == 16'd1);

endmodule

`default_nettype wire

// ==== logic/sg_desc_regs.sv ====
//========================================
// command and descriptor registers
// start pointer capture, next pointer,
// last flag and fetch word select
//========================================
`timescale 1ns/1ps
`default_nettype none

module sg_desc_regs (
   input  logic        wb_clk_i,
   input  logic        wb_rst_i,
   input  logic        rw_i,
   input  logic        ss_we_i,
   input  logic [1:0]  ss_adr_i,
   input  logic [31:0] ss_dat_i,
   input  logic [23:0] ss_dc_i,
   input  logic [31:0] wbs_dat_i,
   input  logic        word_take_i,
   output logic [31:sg_pkg::DESC_ADR_LSB] next_ptr_o,
   output logic        sg_last_o,
   output logic        desc_second_o,
   output logic        cmd_go_o
);

   logic ptr_src;
   logic ptr_dst;

   assign cmd_go_o = ss_we_i && (ss_adr_i == sg_pkg::CMD_DST_DESC);
   assign ptr_src  = ss_we_i && (ss_adr_i == sg_pkg::CMD_SRC_DESC) && !rw_i &&
                     ss_dc_i[sg_pkg::EN_READ_BIT];
   assign ptr_dst  = cmd_go_o && rw_i && ss_dc_i[sg_pkg::EN_WRITE_BIT];

   always_ff @(posedge wb_clk_i) begin
      if (ptr_src || ptr_dst) begin
         next_ptr_o <= ss_dat_i[31:sg_pkg::DESC_ADR_LSB];   // chain head
      end else if (word_take_i && desc_second_o) begin
         next_ptr_o <= wbs_dat_i[31:sg_pkg::DESC_ADR_LSB];
      end
   end

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         sg_last_o     <= 1'b0;
         desc_second_o <= 1'b0;
      end else if (cmd_go_o) begin
         sg_last_o     <= 1'b0;
         desc_second_o <= 1'b0;
      end else if (word_take_i) begin
         if (!desc_second_o) begin
            sg_last_o <= wbs_dat_i[sg_pkg::DESC_LAST_BIT];
         end
         desc_second_o <= !desc_second_o;   // word 0, then next pointer
      end
   end

endmodule

`default_nettype wire

// ==== logic/sg_wb_master.sv ====
//========================================
// Wishbone master
// registered cycle, strobe and write
// enable with a beat address counter
//========================================
`timescale 1ns/1ps
`default_nettype none

module sg_wb_master (
   input  logic        wb_clk_i,
   input  logic        wb_rst_i,
   input  logic        bus_start_i,
   input  logic        addr_sel_i,
   input  logic [31:sg_pkg::DESC_ADR_LSB] next_ptr_i,
   input  logic [31:sg_pkg::DESC_ADR_LSB] buf_adr_i,
   input  logic        bus_inc_i,
   input  logic        bus_stop_i,
   input  logic        bus_we_i,
   output logic        wbs_cyc_o,
   output logic        wbs_stb_o,
   output logic        wbs_we_o,
   output logic [31:0] wbs_adr_o
);

   logic [31:sg_pkg::DESC_ADR_LSB] adr_q;

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         wbs_cyc_o <= 1'b0;
         wbs_stb_o <= 1'b0;
         wbs_we_o  <= 1'b0;
      end else if (bus_stop_i) begin
         wbs_cyc_o <= 1'b0;
         wbs_stb_o <= 1'b0;
         wbs_we_o  <= 1'b0;
      end else if (bus_start_i) begin
         wbs_cyc_o <= 1'b1;
         wbs_stb_o <= 1'b1;   // held through retries and wait states
         wbs_we_o  <= bus_we_i;
      end
   end

   always_ff @(posedge wb_clk_i) begin
      if (bus_start_i) begin
         adr_q <= addr_sel_i ? buf_adr_i : next_ptr_i;
      end else if (bus_inc_i) begin
         adr_q <= adr_q + 1'b1;   // next 8-byte beat
      end
   end

   assign wbs_adr_o = {adr_q, {sg_pkg::DESC_ADR_LSB{1'b0}}};

   // increments and stops only act on a live strobe
   assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      (bus_inc_i || bus_stop_i) |-> wbs_stb_o);

endmodule

`default_nettype wire

// ==== logic/sg_dma_top.sv ====
//========================================
// scatter-gather DMA walker top
// FSM, counters and Wishbone master
//========================================
`timescale 1ns/1ps
`default_nettype none

module sg_dma_top (
   input  logic        wb_clk_i,
   input  logic        wb_rst_i,
   input  logic        ss_we_i,
   input  logic [1:0]  ss_adr_i,
   input  logic [31:0] ss_dat_i,
   input  logic [23:0] ss_dc_i,
   input  logic        rw_i,
   input  logic        ss_done_i,
   input  logic        ss_start_i,
   input  logic        ss_stop_i,
   input  logic        ss_end_i,
   output logic        ss_xfer_o,
   output logic        ss_last_o,
   output logic        wbs_cyc_o,
   output logic        wbs_stb_o,
   output logic        wbs_we_o,
   output logic [31:0] wbs_adr_o,
   input  logic [31:0] wbs_dat_i,
   input  logic [31:0] wbs_dat64_i,
   input  logic        wbs_ack_i,
   input  logic        wbs_err_i,
   input  logic        wbs_rty_i,
   output logic [2:0]  err_o,
   output logic        c_done_o,
   output logic [7:0]  sg_state_o
);

   logic bus_start, addr_sel, bus_inc, bus_stop, bus_we;
   logic buf_load, buf_inc, buf_final, word_take;
   logic desc_second, sg_last, cmd_go;
   logic [31:sg_pkg::DESC_ADR_LSB] next_ptr;
   logic [31:sg_pkg::DESC_ADR_LSB] buf_adr;
   logic [15:0] buf_len;

   sg_ctrl u_ctrl (
      .wb_clk_i(wb_clk_i), .wb_rst_i(wb_rst_i), .rw_i(rw_i),
      .ss_we_i(ss_we_i), .ss_adr_i(ss_adr_i), .ss_dc_i(ss_dc_i),
      .ss_start_i(ss_start_i), .ss_stop_i(ss_stop_i), .ss_end_i(ss_end_i),
      .ss_done_i(ss_done_i), .wbs_ack_i(wbs_ack_i), .wbs_err_i(wbs_err_i),
      .buf_final_i(buf_final), .desc_second_i(desc_second),
      .sg_last_i(sg_last), .cmd_go_i(cmd_go),
      .bus_start_o(bus_start), .addr_sel_o(addr_sel), .bus_inc_o(bus_inc),
      .bus_stop_o(bus_stop), .bus_we_o(bus_we), .buf_load_o(buf_load),
      .buf_inc_o(buf_inc), .word_take_o(word_take), .ss_xfer_o(ss_xfer_o),
      .ss_last_o(ss_last_o), .err_o(err_o), .c_done_o(c_done_o),
      .sg_state_o(sg_state_o)
   );

   sg_buf_cnt u_buf_cnt (
      .wb_clk_i(wb_clk_i), .wb_rst_i(wb_rst_i), .wbs_dat_i(wbs_dat_i),
      .wbs_dat64_i(wbs_dat64_i), .buf_load_i(buf_load), .buf_inc_i(buf_inc),
      .buf_adr_o(buf_adr), .buf_len_o(buf_len), .buf_final_o(buf_final)
   );

   sg_desc_regs u_desc_regs (
      .wb_clk_i(wb_clk_i), .wb_rst_i(wb_rst_i), .rw_i(rw_i),
      .ss_we_i(ss_we_i), .ss_adr_i(ss_adr_i), .ss_dat_i(ss_dat_i),
      .ss_dc_i(ss_dc_i), .wbs_dat_i(wbs_dat_i), .word_take_i(word_take),
      .next_ptr_o(next_ptr), .sg_last_o(sg_last),
      .desc_second_o(desc_second), .cmd_go_o(cmd_go)
   );

   sg_wb_master u_wb_master (
      .wb_clk_i(wb_clk_i), .wb_rst_i(wb_rst_i), .bus_start_i(bus_start),
      .addr_sel_i(addr_sel), .next_ptr_i(next_ptr), .buf_adr_i(buf_adr),
      .bus_inc_i(bus_inc), .bus_stop_i(bus_stop), .bus_we_i(bus_we),
      .wbs_cyc_o(wbs_cyc_o), .wbs_stb_o(wbs_stb_o), .wbs_we_o(wbs_we_o),
      .wbs_adr_o(wbs_adr_o)
   );

   // a new cycle only opens once the previous one has dropped
   assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      bus_start |-> !wbs_cyc_o);

   // the last pulse follows a fully drained buffer
   assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      ss_last_o |-> buf_len == 16'd0);

   assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      wbs_stb_o |-> $onehot0({wbs_ack_i, wbs_err_i, wbs_rty_i}));

endmodule

`default_nettype wire

// ==== verification/sg_wb_mem.sv ====
//========================================
// Wishbone slave memory model
// descriptor storage with random wait
// states, retries and error injection
//========================================
`timescale 1ns/1ps
`default_nettype none

module sg_wb_mem (
   input  logic        wb_clk_i,
   input  logic        wb_rst_i,
   input  logic        cyc_i,
   input  logic        stb_i,
   input  logic [31:0] adr_i,
   input  logic [2:0]  rnd_i,       // wait count and retry bit
   input  logic        err_en_i,
   input  logic [31:0] err_adr_i,
   output logic [31:0] dat_o,
   output logic [31:0] dat64_o,
   output logic        ack_o,
   output logic        err_o,
   output logic        rty_o
);

   logic [63:0] words [0:1023];   // one 8-byte beat per entry
   logic [1:0]  wait_q;
   logic        busy_q;

   initial begin
      for (int i = 0; i < 1024; i++) begin
         words[i] = {32'h5a00_0000 ^ 32'(i), 32'(i) << 3};
      end
   end

   assign dat_o   = words[adr_i[12:3]][31:0];
   assign dat64_o = words[adr_i[12:3]][63:32];

   always @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         ack_o  <= 1'b0;
         err_o  <= 1'b0;
         rty_o  <= 1'b0;
         wait_q <= 2'd0;
         busy_q <= 1'b0;
      end else begin
         ack_o <= 1'b0;
         err_o <= 1'b0;
         rty_o <= 1'b0;
         if (!(cyc_i && stb_i)) begin
            busy_q <= 1'b0;
         end else if (!ack_o && !err_o) begin
            if (!busy_q) begin
               busy_q <= 1'b1;
               wait_q <= rnd_i[1:0];   // 0 to 3 wait states
            end else if (wait_q == 2'd0) begin
               busy_q <= 1'b0;
               if (err_en_i && adr_i == err_adr_i) begin
                  err_o <= 1'b1;
               end else begin
                  ack_o <= 1'b1;
               end
            end else begin
               wait_q <= wait_q - 2'd1;
               rty_o  <= rnd_i[2];   // retry keeps strobe up
            end
         end
      end
   end

endmodule

`default_nettype wire

// ==== verification/tb_sg_dma.sv ====
//========================================
// scatter-gather DMA walker testbench
// builds descriptor chains, plays sequencer
// and data side, checks every bus beat
//========================================
`timescale 1ns/1ps
`default_nettype none

module tb_sg_dma;

   logic        wb_clk_i = 1'b0;
   logic        wb_rst_i;
   logic        ss_we_i, rw_i, ss_done_i, ss_start_i, ss_stop_i, ss_end_i;
   logic [1:0]  ss_adr_i;
   logic [31:0] ss_dat_i;
   logic [23:0] ss_dc_i;
   logic        ss_xfer_o, ss_last_o, wbs_cyc_o, wbs_stb_o, wbs_we_o, c_done_o;
   logic [31:0] wbs_adr_o, wbs_dat_i, wbs_dat64_i;
   logic        wbs_ack_i, wbs_err_i, wbs_rty_i;
   logic [2:0]  err_o, mem_rnd, rnd_bits;
   logic [7:0]  sg_state_o;
   logic        err_en;
   logic [31:0] err_adr;
   logic [15:0] chain_seed = 16'd50;
   logic [15:0] dly_seed   = 16'd50;
   logic        pause_mode = 1'b0;
   logic [32:0] exp_q[$];
   logic [32:0] exp_beat;
   int          n_desc, errors = 0, checks = 0, budget = 400, elapsed = 0;
   int          xfer_cnt, last_cnt, cyc_cnt, total;
   logic [31:0] desc_ptr [0:4];
   logic [31:0] desc_buf [0:4];
   int          desc_len [0:4];

   always #2 wb_clk_i = ~wb_clk_i;

   sg_dma_top dut (.*);

   sg_wb_mem mem (
      .wb_clk_i(wb_clk_i), .wb_rst_i(wb_rst_i), .cyc_i(wbs_cyc_o), .stb_i(wbs_stb_o),
      .adr_i(wbs_adr_o), .rnd_i(mem_rnd), .err_en_i(err_en), .err_adr_i(err_adr),
      .dat_o(wbs_dat_i), .dat64_o(wbs_dat64_i), .ack_o(wbs_ack_i), .err_o(wbs_err_i),
      .rty_o(wbs_rty_i)
   );

   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);   // Galois form with taps 16 14 13 11
   endfunction

   task automatic draw(input int n, output logic [7:0] v);
      v = 8'd0;
      for (int i = 0; i < n; i++) begin
         v          = {v[6:0], chain_seed[0]};
         chain_seed = lfsr_next(chain_seed);
      end
   endtask

   // address of the n-th buffer beat over the whole chain
   function automatic logic [31:0] ref_beat(input int n, output int sum);
      logic [31:0] adr;
      int          base;
      adr  = 32'd0;
      base = 0;
      for (int k = 0; k < n_desc; k++) begin
         if (n >= base && n < base + desc_len[k]) adr = desc_buf[k] + 32'((n - base) * 8);
         base += desc_len[k];
      end
      sum = base;
      return adr;
   endfunction

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic build_chain(input logic we);
      logic [7:0] v;
      int         g;
      draw(2, v);
      n_desc = 3 + (v % 3);
      for (int k = 0; k < n_desc; k++) begin
         draw(3, v);
         desc_len[k] = 1 + v;
         draw(8, v);
         desc_buf[k] = 32'h0010_0000 + (32'(k) << 12) + (32'(v) << 3);
         desc_ptr[k] = 32'h1000 + 32'((4 - k) * 32);   // chain runs downward
      end
      exp_q.delete();
      g = 0;
      for (int k = 0; k < n_desc; k++) begin
         mem.words[desc_ptr[k][12:3]] = {desc_buf[k], 11'd0, k == n_desc - 1, 1'b0,
                                         16'(desc_len[k]), 3'd0};
         mem.words[desc_ptr[k][12:3] + 1] = {32'd0, desc_ptr[(k + 1) % 5]};
         exp_q.push_back({1'b0, desc_ptr[k]});
         exp_q.push_back({1'b0, desc_ptr[k] + 32'd8});
         for (int b = 0; b < desc_len[k]; b++) begin
            exp_q.push_back({we, ref_beat(g, total)});
            g++;
         end
      end
      budget += total * 20 + 200;
      xfer_cnt = 0;
      last_cnt = 0;
      cyc_cnt  = 0;
   endtask

   // sequencer writes ctrl, source pointer, then destination as go
   task automatic send_cmd(input logic we, input logic [23:0] dc);
      @(posedge wb_clk_i);
      rw_i     <= we;
      ss_dc_i  <= dc;
      ss_we_i  <= 1'b1;
      ss_adr_i <= sg_pkg::CMD_CTRL;
      @(posedge wb_clk_i);
      ss_adr_i <= sg_pkg::CMD_SRC_DESC;
      ss_dat_i <= we ? 32'hdead_0000 : desc_ptr[0];
      @(posedge wb_clk_i);
      ss_adr_i <= sg_pkg::CMD_DST_DESC;
      ss_dat_i <= we ? desc_ptr[0] : 32'hbeef_0000;
      @(posedge wb_clk_i);
      ss_we_i  <= 1'b0;
   endtask

   task automatic wait_done();
      @(negedge wb_clk_i);
      while (!c_done_o) @(negedge wb_clk_i);
   endtask

   task automatic release_end();
      @(posedge wb_clk_i);
      ss_done_i <= 1'b1;
      @(posedge wb_clk_i);
      ss_done_i <= 1'b0;
      @(negedge wb_clk_i);
      check_val("sg_state_o", 32'(sg_state_o[2:0]), 32'(sg_pkg::ST_IDLE));
   endtask

   task automatic full_job(input logic we);
      build_chain(we);
      send_cmd(we, 24'h000006);
      wait_done();
      check_val("ss_xfer_o count", xfer_cnt, total + 1);
      check_val("ss_last_o count", last_cnt, 1);
      check_val("pending beats", exp_q.size(), 0);
      check_val("sg_state_o", 32'(sg_state_o[2:0]), 32'(sg_pkg::ST_END));
      check_val("sg_state_o last flag", 32'(sg_state_o[7]), 1);
      release_end();
   endtask

   always @(posedge wb_clk_i) begin
      for (int i = 0; i < 3; i++) begin
         rnd_bits[i] = dly_seed[0];
         dly_seed    = lfsr_next(dly_seed);
      end
      mem_rnd <= rnd_bits;
   end

   // random pause periods on the data side
   always @(posedge wb_clk_i) begin
      logic [7:0] v;
      if (pause_mode) begin
         draw(1, v);
         ss_stop_i  <= v[0];
         ss_start_i <= !v[0];
      end
   end

   always @(posedge wb_clk_i) begin
      if (!wb_rst_i) begin
         if (wbs_cyc_o && wbs_stb_o && wbs_ack_i) begin
            if (exp_q.size() == 0) begin
               errors++;
               $display("bus beat at %0t to %h was not expected", $time, wbs_adr_o);
            end else begin
               exp_beat = exp_q.pop_front();
               check_val("wbs_adr_o", wbs_adr_o, exp_beat[31:0]);
               check_val("wbs_we_o", 32'(wbs_we_o), 32'(exp_beat[32]));
            end
         end
         if (ss_xfer_o) xfer_cnt++;
         if (ss_last_o) last_cnt++;
         if (wbs_cyc_o) cyc_cnt++;
      end
   end

   initial begin
      forever begin
         @(posedge wb_clk_i);
         elapsed++;
         if (elapsed > budget) begin
            $display("watchdog expired: the walker did not finish its jobs in time");
            $display("Done: errors found");
            $finish;
         end
      end
   end

   initial begin
      wb_rst_i   = 1'b1;
      {ss_we_i, rw_i, ss_done_i, ss_stop_i, ss_end_i, err_en} = '0;
      ss_start_i = 1'b1;
      ss_adr_i   = 2'd0;
      ss_dat_i   = 32'd0;
      ss_dc_i    = 24'd0;
      err_adr    = 32'd0;
      repeat (8) @(posedge wb_clk_i);
      wb_rst_i <= 1'b0;
      full_job(1'b0);                    // read direction
      full_job(1'b1);                    // write direction
      pause_mode = 1'b1;
      full_job(1'b0);
      pause_mode = 1'b0;
      @(posedge wb_clk_i);
      ss_stop_i  <= 1'b0;
      ss_start_i <= 1'b1;
      build_chain(1'b0);                 // early end
      @(posedge wb_clk_i);
      ss_stop_i <= 1'b1;
      send_cmd(1'b0, 24'h000006);
      while (xfer_cnt == 0) @(negedge wb_clk_i);
      @(posedge wb_clk_i);
      ss_start_i <= 1'b0;
      ss_end_i   <= 1'b1;
      wait_done();
      check_val("ss_last_o count", last_cnt, 0);
      check_val("sg_state_o", 32'(sg_state_o[2:0]), 32'(sg_pkg::ST_END));
      check_val("sg_state_o last flag", 32'(sg_state_o[7]), 0);
      release_end();
      @(posedge wb_clk_i);
      ss_end_i   <= 1'b0;
      ss_stop_i  <= 1'b0;
      ss_start_i <= 1'b1;
      build_chain(1'b0);                 // direction disabled
      send_cmd(1'b0, 24'h000004);
      repeat (10) @(negedge wb_clk_i);
      check_val("wbs_cyc_o cycles", cyc_cnt, 0);
      check_val("c_done_o", 32'(c_done_o), 1);
      check_val("sg_state_o", 32'(sg_state_o[2:0]), 32'(sg_pkg::ST_IDLE));
      build_chain(1'b0);                 // bus error on the first buffer beat
      err_adr = ref_beat(0, total);
      err_en  = 1'b1;
      send_cmd(1'b0, 24'h000006);
      while (sg_state_o[2:0] != sg_pkg::ST_PANIC) @(negedge wb_clk_i);
      check_val("wbs_cyc_o", 32'(wbs_cyc_o), 0);
      check_val("wbs_stb_o", 32'(wbs_stb_o), 0);
      check_val("err_o", 32'(err_o), 32'(sg_pkg::ST_BUF_REQ));
      repeat (5) @(negedge wb_clk_i);
      check_val("c_done_o", 32'(c_done_o), 0);
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== flist.f ====
logic/sg_pkg.sv
logic/sg_ctrl.sv
logic/sg_buf_cnt.sv
logic/sg_desc_regs.sv
logic/sg_wb_master.sv
logic/sg_dma_top.sv
verification/sg_wb_mem.sv
verification/tb_sg_dma.sv

// ==== run.sh ====
#!/bin/sh
# build the scatter-gather DMA testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_sg_dma -f flist.f -o tb_sg_dma_sim \
   && ./obj_dir/tb_sg_dma_sim | grep -F "Done: no errors" \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
